/* testbench/ppu_vectors.txt */
# columns: stall valid op a b expected, all hex
# op 0 add, 1 sub, 2 mul, 3 i2p
0 0 0 00 00 00
0 1 0 40 40 60
0 1 0 50 30 62
0 1 0 68 c0 60
0 1 1 48 48 00
0 1 0 40 02 41
0 1 0 7a 08 7a
0 1 1 20 68 9c
0 1 0 70 30 72
1 0 0 00 00 00
1 0 0 00 00 00
0 1 0 f0 74 74
0 1 2 50 50 62
0 1 2 68 9c 89
0 1 2 7c 7c 7f
0 1 2 01 01 01
0 1 2 82 78 81
0 1 2 41 50 52
1 0 0 00 00 00
0 1 3 05 00 72
0 1 3 fd 00 98
0 1 3 00 00 00
0 1 3 64 00 7f
0 1 3 14 00 7c
0 1 3 80 00 81
0 1 0 80 40 80
0 1 2 60 80 80
0 1 2 68 00 00
0 1 0 00 9c 9c
0 1 0 58 00 58
0 1 1 00 50 b0

/* sources.f */
+incdir+common
common/ppu_types_pkg.sv
common/ppu_ops_pkg.sv
common/ppu_fir_if.sv
source/ppu_pipe_ctrl.sv
core_ops/ppu_extraction.sv
core_ops/ppu_fir_ops.sv
core_ops/ppu_normalization.sv
source/ppu_top.sv
testbench/ppu_checker.sv
testbench/tb_ppu_top.sv

/* Makefile */
# Verilator build and run of the posit unit testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
VECS := testbench/ppu_vectors.txt
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(VECS)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_top
  import ppu_ops_pkg::*;
();

  localparam int    CLK_PERIOD    = 100;
  localparam int    DRIVE_DELAY   = 5;
  localparam int    DRAIN_TIMEOUT = 20;
  localparam string VEC_FILE      = "testbench/ppu_vectors.txt";

  logic        clk_i;
  logic        rst_n_i;
  logic        valid_i;
  logic        stall_i;
  logic [1:0]  op_i;
  logic [7:0]  a_i;
  logic [7:0]  b_i;
  logic [7:0]  expected;
  logic        valid_o;
  logic [7:0]  pout_o;
  int          checked;
  int          errors;
  // op, a, b of every item handed to the DUT
  logic [17:0] sent_q[$];

  ppu_top ppu_top_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .stall_i (stall_i),
    .op_i    (op_i),
    .a_i     (a_i),
    .b_i     (b_i),
    .valid_o (valid_o),
    .pout_o  (pout_o)
  );

  ppu_checker checker_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .stall_i     (stall_i),
    .op_i        (op_i),
    .a_i         (a_i),
    .b_i         (b_i),
    .expected_i  (expected),
    .dut_valid_i (valid_o),
    .dut_pout_i  (pout_o),
    .checked_o   (checked),
    .errors_o    (errors)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  task automatic apply_vector(input logic stall, input logic valid, input logic [1:0] op,
                              input logic [7:0] a, input logic [7:0] b, input logic [7:0] exp);
    stall_i  = stall;
    // nothing enters while the pipe is frozen
    valid_i  = valid & ~stall;
    op_i     = op;
    a_i      = a;
    b_i      = b;
    expected = exp;
    if (valid && !stall) begin
      sent_q.push_back({op, a, b});
    end
  endtask

  initial begin
    int         fd;
    int         fields;
    int         cycles;
    string      line;
    logic [7:0] v_stall;
    logic [7:0] v_valid;
    logic [7:0] v_op;
    logic [7:0] v_a;
    logic [7:0] v_b;
    logic [7:0] v_exp;
    logic       open_failed;
    logic       timed_out;
    operation_e op_v;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    stall_i     = 1'b0;
    op_i        = '0;
    a_i         = '0;
    b_i         = '0;
    expected    = '0;
    open_failed = 1'b0;
    repeat (2) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_n_i = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // one vector line per cycle
    ////////////////////////////////////////////////////////////////////////////
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("could not open the vector file %s", VEC_FILE);
      open_failed = 1'b1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        fields = $sscanf(line, "%h %h %h %h %h %h", v_stall, v_valid, v_op, v_a, v_b, v_exp);
        // comment and blank lines carry no fields
        if (fields == 6) begin
          @(posedge clk_i);
          #(DRIVE_DELAY);
          apply_vector(v_stall[0], v_valid[0], v_op[1:0], v_a, v_b, v_exp);
        end
      end
      $fclose(fd);
    end
    @(posedge clk_i);
    #(DRIVE_DELAY);
    apply_vector(1'b0, 1'b0, 2'b00, 8'h00, 8'h00, 8'h00);

    cycles = 0;
    while (checked < sent_q.size() && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    timed_out = checked < sent_q.size();
    if (timed_out) begin
      for (int i = checked; i < sent_q.size(); i++) begin
        op_v = operation_e'(sent_q[i][17:16]);
        $display("item %0d (%s a=%h b=%h) never came out of the DUT", i + 1, op_v.name(),
                 sent_q[i][15:8], sent_q[i][7:0]);
      end
    end
    $display("%0d items sent, %0d checked, %0d errors", sent_q.size(), checked, errors);
    if (!open_failed && !timed_out && errors == 0 && sent_q.size() > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_ppu_top

`default_nettype wire

/* testbench/ppu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_checker
  import ppu_ops_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       valid_i,
  input  logic       stall_i,
  input  logic [1:0] op_i,
  input  logic [7:0] a_i,
  input  logic [7:0] b_i,
  input  logic [7:0] expected_i,
  input  logic       dut_valid_i,
  input  logic [7:0] dut_pout_i,
  output int         checked_o,
  output int         errors_o
);

  // op, a, b and expected posit of each accepted item, oldest first
  logic [25:0] pending_q[$];
  int          checked = 0;
  int          errors  = 0;

  assign checked_o = checked;
  assign errors_o  = errors;

  function automatic string operand_text(input operation_e op, input logic [7:0] a,
                                         input logic [7:0] b);
    if (uses_int_operand(op)) begin
      return $sformatf("int %0d", $signed(a));
    end
    return $sformatf("a=%h b=%h", a, b);
  endfunction

  function automatic void compare_item(input logic [25:0] item, input logic [7:0] got);
    operation_e op;
    logic [7:0] exp;
    op  = operation_e'(item[25:24]);
    exp = item[7:0];
    checked++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s %s gave %h, expected %h", $time, op.name(),
               operand_text(op, item[23:16], item[15:8]), got, exp);
    end else begin
      $display("item %0d %s %s -> %h ok", checked, op.name(),
               operand_text(op, item[23:16], item[15:8]), got);
    end
  endfunction

  // half a cycle after the edge everything is settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if ($isunknown(dut_valid_i)) begin
        errors++;
        $display("valid_o is unknown at %0t", $time);
      end else if (dut_valid_i && !stall_i) begin
        // this output leaves the pipe at the next edge
        if (pending_q.size() == 0) begin
          errors++;
          $display("output %h appeared at %0t with no item waiting for it", dut_pout_i, $time);
        end else begin
          compare_item(pending_q.pop_front(), dut_pout_i);
        end
      end
      if (valid_i && !stall_i) begin
        pending_q.push_back({op_i, a_i, b_i, expected_i});
      end
    end
  end

endmodule : ppu_checker

`default_nettype wire

/* source/ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_top
  import ppu_types_pkg::*;
  import ppu_ops_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       valid_i,
  input  logic       stall_i,
  input  logic [1:0] op_i,
  input  logic [7:0] a_i,
  input  logic [7:0] b_i,
  output logic       valid_o,
  output logic [7:0] pout_o
);

  logic     adv;
  result_t  result;
  special_t special;

  ppu_fir_if fir_if ();

  ppu_pipe_ctrl ppu_pipe_ctrl_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .stall_i (stall_i),
    .adv_o   (adv),
    .valid_o (valid_o)
  );

  //////////////////////////////////////////////////////////////////////////
  // datapath, one register per stage
  //////////////////////////////////////////////////////////////////////////

  ppu_extraction ppu_extraction_i (
    .clk_i (clk_i),
    .adv_i (adv),
    .op_i  (operation_e'(op_i)),
    .a_i   (operand_u'(a_i)),
    .b_i   (operand_u'(b_i)),
    .fir_o (fir_if.extraction_mp)
  );

  ppu_fir_ops ppu_fir_ops_i (
    .clk_i     (clk_i),
    .adv_i     (adv),
    .fir_i     (fir_if.ops_mp),
    .result_o  (result),
    .special_o (special)
  );

  ppu_normalization ppu_normalization_i (
    .clk_i     (clk_i),
    .adv_i     (adv),
    .result_i  (result),
    .special_i (special),
    .pout_o    (pout_o)
  );

endmodule : ppu_top

`default_nettype wire

/* core_ops/ppu_normalization.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_defs.svh"

module ppu_normalization
  import ppu_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     adv_i,
  input  result_t  result_i,
  input  special_t special_i,
  output posit_t   pout_o
);

  // largest regime value, maxpos is 2^KMAX
  localparam int KMAX = `PPU_N - 2;

  logic [3:0]        lead;
  logic [15:0]       norm;
  logic signed [7:0] exp_w;
  logic signed [7:0] te_n;
  logic signed [7:0] k;
  logic signed [7:0] neg_k;
  logic [31:0]       str;
  logic [`PPU_N-2:0] body;
  logic [`PPU_N-2:0] body_r;
  logic              guard;
  logic              sticky;
  logic              rnd_up;
  logic [`PPU_N-1:0] mag;
  posit_t            pout_n;

  always_comb begin
    lead = '0;
    for (int i = 0; i < 16; i++) begin
      if (result_i.mant[i]) begin
        lead = 4'(i);
      end
    end
    // leading one to bit 15, exponent corrected for the 2.14 format
    norm  = result_i.mant << (4'd15 - lead);
    exp_w = result_i.exp;
    te_n  = exp_w + $signed({4'b0000, lead}) - 8'sd14;
    k     = te_n >>> `PPU_ES;
    neg_k = -k - 8'sd1;

    // regime run and terminator ahead of the fraction, left aligned
    if (k >= 0) begin
      str = $signed({2'b10, norm[14:0], 15'b0}) >>> k[2:0];
    end else begin
      str = {2'b01, norm[14:0], 15'b0} >> neg_k[2:0];
    end

    body   = str[31:25];
    guard  = str[24];
    sticky = |str[23:0];
    // nearest, ties to the even pattern
    rnd_up = guard & (sticky | body[0]);

    // outside the posit range saturate, never round to zero
    if (k > KMAX) begin
      body_r = POSIT_MAXPOS[`PPU_N-2:0];
    end else if (k < -KMAX) begin
      body_r = POSIT_MINPOS[`PPU_N-2:0];
    end else begin
      body_r = body + {{(`PPU_N-2){1'b0}}, rnd_up};
    end

    mag = {1'b0, body_r};
    if (special_i.is_nar) begin
      pout_n = POSIT_NAR;
    end else if (special_i.is_zero) begin
      pout_n = POSIT_ZERO;
    end else begin
      pout_n = result_i.sign ? -mag : mag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (adv_i) begin
      pout_o <= pout_n;
    end
  end

  // NaR flagged upstream must come out as the NaR word
  nar_pack_a : assert property (
    @(posedge clk_i)
    adv_i && special_i.is_nar |=> pout_o == POSIT_NAR
  ) else begin
    $error("NaR special packed to %h", pout_o);
  end

endmodule : ppu_normalization

`default_nettype wire

/* core_ops/ppu_fir_ops.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_defs.svh"

module ppu_fir_ops
  import ppu_types_pkg::*;
  import ppu_ops_pkg::*;
(
  input  logic       clk_i,
  input  logic       adv_i,
  ppu_fir_if.ops_mp  fir_i,
  output result_t    result_o,
  output special_t   special_o
);

  fir_t                         hi_f;
  fir_t                         lo_f;
  logic                         a_ge;
  logic signed [`PPU_TE_BITS:0] te1;
  logic signed [`PPU_TE_BITS:0] te2;
  logic signed [`PPU_TE_BITS:0] te_diff;
  logic [15:0]                  m_hi;
  logic [31:0]                  m_lo_wide;
  logic [15:0]                  m_lo;
  logic [15:0]                  m_sum;
  logic                         eff_sub;
  logic [2*`PPU_MANT_BITS-1:0]  prod;
  result_t                      res_n;
  special_t                     spec_n;

  always_comb begin
    te1 = fir_i.fir1.te;
    te2 = fir_i.fir2.te;

    // order by magnitude so the aligned difference stays non-negative
    a_ge    = te1 > te2 || (te1 == te2 && fir_i.fir1.mant >= fir_i.fir2.mant);
    hi_f    = a_ge ? fir_i.fir1 : fir_i.fir2;
    lo_f    = a_ge ? fir_i.fir2 : fir_i.fir1;
    te_diff = a_ge ? te1 - te2 : te2 - te1;

    // 1.6 mantissa placed at bit 14, low bits give the shift room
    m_hi      = {1'b0, hi_f.mant, 8'b0};
    m_lo_wide = {1'b0, lo_f.mant, 24'b0} >> te_diff;
    // whatever falls off the window is kept as sticky
    m_lo      = {m_lo_wide[31:17], m_lo_wide[16] | (|m_lo_wide[15:0])};
    eff_sub   = fir_i.fir1.sign ^ fir_i.fir2.sign;
    m_sum     = eff_sub ? m_hi - m_lo : m_hi + m_lo;

    // exact product of two 1.6 mantissas, 2.12 format
    prod = fir_i.fir1.mant * fir_i.fir2.mant;

    spec_n = fir_i.special;
    case (fir_i.op)
      ADD, SUB: begin
        res_n.sign = hi_f.sign;
        res_n.exp  = a_ge ? te1 : te2;
        res_n.mant = m_sum;
        // equal magnitudes with opposite signs cancel exactly
        if (m_sum == '0 && !spec_n.is_nar) begin
          spec_n.is_zero = 1'b1;
        end
      end
      MUL: begin
        res_n.sign = fir_i.fir1.sign ^ fir_i.fir2.sign;
        res_n.exp  = te1 + te2;
        res_n.mant = {prod, 2'b00};
      end
      default: begin
        // I2P and the zero-addend case just forward operand 1
        res_n.sign = fir_i.fir1.sign;
        res_n.exp  = te1;
        res_n.mant = {1'b0, fir_i.fir1.mant, 8'b0};
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (adv_i) begin
      result_o  <= res_n;
      special_o <= spec_n;
    end
  end

endmodule : ppu_fir_ops

`default_nettype wire

/* core_ops/ppu_extraction.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_defs.svh"

module ppu_extraction
  import ppu_types_pkg::*;
  import ppu_ops_pkg::*;
(
  input  logic             clk_i,
  input  logic             adv_i,
  input  operation_e       op_i,
  input  operand_u         a_i,
  input  operand_u         b_i,
  ppu_fir_if.extraction_mp fir_o
);

  // regime run gives the total exponent, no exponent field with es 0
  function automatic fir_t posit_to_fir(input posit_t p);
    posit_t                         mag;
    logic [`PPU_N-2:0]              body;
    logic [`PPU_N-2:0]              frac_sh;
    logic                           lead;
    logic [2:0]                     run;
    logic signed [`PPU_TE_BITS-1:0] run_s;
    fir_t                           f;
    mag  = p[`PPU_N-1] ? -p : p;
    body = mag[`PPU_N-2:0];
    lead = body[`PPU_N-2];
    run  = 3'(`PPU_N - 1);
    // highest bit that breaks the run terminates the regime
    for (int i = 0; i < `PPU_N - 1; i++) begin
      if (body[i] != lead) begin
        run = 3'(`PPU_N - 2 - i);
      end
    end
    run_s   = {2'b00, run};
    frac_sh = body << ({1'b0, run} + 4'd1);
    f.sign  = p[`PPU_N-1];
    f.te    = lead ? run_s - 1 : -run_s;
    f.mant  = {1'b1, frac_sh[`PPU_N-2:1]};
    return f;
  endfunction

  // leading one of the magnitude sets exponent and hidden bit
  function automatic fir_t int_to_fir(input logic signed [`PPU_N-1:0] v);
    logic [`PPU_N-1:0] mag;
    logic [`PPU_N-1:0] norm;
    logic [2:0]        msb;
    fir_t              f;
    mag = v[`PPU_N-1] ? -v : v;
    msb = '0;
    for (int i = 0; i < `PPU_N; i++) begin
      if (mag[i]) begin
        msb = 3'(i);
      end
    end
    norm   = mag << (3'(`PPU_N - 1) - msb);
    f.sign = v[`PPU_N-1];
    f.te   = {2'b00, msb};
    f.mant = norm[`PPU_N-1:1];
    return f;
  endfunction

  operation_e op_n;
  fir_t       fa;
  fir_t       fb;
  fir_t       fir1_n;
  special_t   spec_n;
  logic       int_op;
  logic       a_zero;
  logic       b_zero;

  always_comb begin
    int_op = uses_int_operand(op_i);
    a_zero = a_i.p == POSIT_ZERO;
    b_zero = b_i.p == POSIT_ZERO;
    fa     = int_op ? int_to_fir(a_i.i) : posit_to_fir(a_i.p);
    fb     = posit_to_fir(b_i.p);
    // subtract as add of the negated second operand
    if (op_i == SUB) begin
      fb.sign = ~fb.sign;
    end

    // a zero addend reduces the op to a pass of the other operand
    op_n   = op_i;
    fir1_n = fa;
    if ((op_i == ADD || op_i == SUB) && b_zero) begin
      op_n = I2P;
    end else if ((op_i == ADD || op_i == SUB) && a_zero) begin
      op_n   = I2P;
      fir1_n = fb;
    end

    spec_n.is_nar = !int_op && (a_i.p == POSIT_NAR || b_i.p == POSIT_NAR);
    case (op_i)
      MUL:     spec_n.is_zero = !spec_n.is_nar && (a_zero || b_zero);
      I2P:     spec_n.is_zero = a_zero;
      default: spec_n.is_zero = !spec_n.is_nar && a_zero && b_zero;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (adv_i) begin
      fir_o.op      <= op_n;
      fir_o.fir1    <= fir1_n;
      fir_o.fir2    <= fb;
      fir_o.special <= spec_n;
    end
  end

endmodule : ppu_extraction

`default_nettype wire

/* source/ppu_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_pipe_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  input  logic stall_i,
  output logic adv_o,
  output logic valid_o
);

  // [0] extraction, [1] fir ops, [2] normalization
  logic [2:0] valid_q;

  // one stall level freezes every stage at once
  assign adv_o = ~stall_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (adv_o) begin
      valid_q <= {valid_q[1:0], valid_i};
    end
  end

  assign valid_o = valid_q[2];

  ////////////////////////////////////////////////////////////////////////////
  // pipeline checks
  ////////////////////////////////////////////////////////////////////////////

  // the output strobe holds while the pipe is frozen
  valid_hold_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    stall_i |=> $stable(valid_o)
  ) else begin
    $error("valid_o changed while stall_i was high");
  end

  // once out of reset no stage carries an unknown valid bit
  valid_known_a : assert property (
    @(posedge clk_i)
    rst_n_i |-> !$isunknown({valid_q, adv_o})
  ) else begin
    $error("unknown valid or advance after reset");
  end

endmodule : ppu_pipe_ctrl

`default_nettype wire

/* common/ppu_fir_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ppu_fir_if
  import ppu_types_pkg::*;
  import ppu_ops_pkg::*;
();

  // stage-1 registers, meaningful while the stage-1 valid bit is set
  operation_e op;
  fir_t       fir1;
  fir_t       fir2;
  special_t   special;

  modport extraction_mp (
    output op,
    output fir1,
    output fir2,
    output special
  );

  modport ops_mp (
    input op,
    input fir1,
    input fir2,
    input special
  );

endinterface : ppu_fir_if

`default_nettype wire

/* common/ppu_ops_pkg.sv */
`default_nettype none

package ppu_ops_pkg;

  // encoding as seen on op_i
  typedef enum logic [1:0] {
    ADD = 2'b00,
    SUB = 2'b01,
    MUL = 2'b10,
    I2P = 2'b11
  } operation_e;

  // first operand is an integer rather than a posit
  function automatic logic uses_int_operand(input operation_e op);
    return op == I2P;
  endfunction

endpackage : ppu_ops_pkg

`default_nettype wire

/* common/ppu_types_pkg.sv */
`default_nettype none

`include "ppu_defs.svh"

package ppu_types_pkg;

  typedef logic [`PPU_N-1:0] posit_t;

  // reserved and boundary words
  localparam posit_t POSIT_ZERO   = '0;
  localparam posit_t POSIT_NAR    = {1'b1, {(`PPU_N-1){1'b0}}};
  localparam posit_t POSIT_MAXPOS = {1'b0, {(`PPU_N-1){1'b1}}};
  localparam posit_t POSIT_MINPOS = {{(`PPU_N-1){1'b0}}, 1'b1};

  // one operand word, a posit for arithmetic or a signed integer for I2P
  typedef union packed {
    posit_t                   p;
    logic signed [`PPU_N-1:0] i;
  } operand_u;

  // value is (-1)^sign * 2^te * mant, hidden one at the mantissa msb
  typedef struct packed {
    logic                           sign;
    logic signed [`PPU_TE_BITS-1:0] te;
    logic [`PPU_MANT_BITS-1:0]      mant;
  } fir_t;

  typedef struct packed {
    logic is_zero;
    logic is_nar;
  } special_t;

  // mant is 2 integer bits over 14 fraction bits, lsb also carries sticky
  typedef struct packed {
    logic                         sign;
    logic signed [`PPU_TE_BITS:0] exp;
    logic [15:0]                  mant;
  } result_t;

endpackage : ppu_types_pkg

`default_nettype wire

/* common/ppu_defs.svh */
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// posit word and exponent field
`define PPU_N         8
`define PPU_ES        0

// signed total exponent of a decoded operand
`define PPU_TE_BITS   5

// mantissa width, hidden one included
`define PPU_MANT_BITS 7

`endif
